// ==== board.f ====
rtl/board_pkg.sv
rtl/board_timer.sv
rtl/board_reset_seq.sv
rtl/board_inputs.sv
rtl/board_dip.sv
rtl/board_led.sv
rtl/board_top.sv
testbench/board_tb.sv

// ==== testbench/board_tb.sv ====
// ################################################
// Board support testbench
// Reference models and assertions around board_top
// ################################################
`timescale 1ns/1ps

module board_tb;
    import board_pkg::*;

    localparam int HOLD_LEN      = 8;
    localparam int INIT_LEN      = 16;
    localparam int GAME_LEN      = 12;
    localparam int COUNT_W       = 6;
    localparam int BLINK_FRAMES  = 2;
    localparam int ACTIVE_LOW    = 1;
    localparam int PERIOD        = 40;
    localparam int TEST_CYCLES   = 420;
    localparam int MARGIN_CYCLES = 100;
    localparam logic IDLE        = ACTIVE_LOW != 0;

    logic                   clk_sys = 1'b0;
    logic                   reset;
    logic                   rst_req;
    logic                   downloading;
    logic [BOARD_JOY_W-1:0] board_joystick1;
    logic [BOARD_JOY_W-1:0] board_joystick2;
    logic [PLAYERS-1:0]     board_coin;
    logic [PLAYERS-1:0]     board_start;
    logic [STATUS_W-1:0]    status;
    logic                   LVBL;
    logic                   osd_shown;
    logic                   game_led;
    logic                   rst;
    logic                   sdram_init;
    logic                   game_rst;
    logic [JOY_W-1:0]       game_joystick1;
    logic [JOY_W-1:0]       game_joystick2;
    logic [PLAYERS-1:0]     game_coin;
    logic [PLAYERS-1:0]     game_start;
    logic                   dip_test;
    logic                   dip_pause;
    logic                   dip_flip;
    logic                   enable_fm;
    logic                   enable_psg;
    logic                   led;
    logic [1:0]             dip_fxlevel;
    logic [1:0]             rotate;

    // Expected values
    int                 edge_n;
    int                 game_left;
    int                 frames;
    logic               waiting;
    logic               rst_m;
    logic               init_m;
    logic               game_m;
    logic [JOY_W-1:0]   joy1_m;
    logic [JOY_W-1:0]   joy2_m;
    logic [PLAYERS-1:0] coin_m;
    logic [PLAYERS-1:0] start_m;
    logic               pause_m;
    logic               pause_prev;
    logic               combo_prev;
    logic               soft_m;
    logic               test_m;
    logic               dpause_m;
    logic               flip_m;
    logic               fm_m;
    logic               psg_m;
    logic [1:0]         fx_m;
    logic [1:0]         rot_m;
    logic               led_m;
    logic               lvbl_prev;
    logic               dl_prev;
    logic               blink_m;
    logic               checking;
    integer             seed;

    board_top #(
        .HOLD_LEN       ( HOLD_LEN        ),
        .INIT_LEN       ( INIT_LEN        ),
        .GAME_LEN       ( GAME_LEN        ),
        .COUNT_W        ( COUNT_W         ),
        .BLINK_FRAMES   ( BLINK_FRAMES    ),
        .ACTIVE_LOW     ( ACTIVE_LOW      )
    ) DUT (
        .clk_sys        ( clk_sys         ),
        .reset          ( reset           ),
        .rst_req        ( rst_req         ),
        .downloading    ( downloading     ),
        .board_joystick1( board_joystick1 ),
        .board_joystick2( board_joystick2 ),
        .board_coin     ( board_coin      ),
        .board_start    ( board_start     ),
        .status         ( status          ),
        .LVBL           ( LVBL            ),
        .osd_shown      ( osd_shown       ),
        .game_led       ( game_led        ),
        .rst            ( rst             ),
        .sdram_init     ( sdram_init      ),
        .game_rst       ( game_rst        ),
        .game_joystick1 ( game_joystick1  ),
        .game_joystick2 ( game_joystick2  ),
        .game_coin      ( game_coin       ),
        .game_start     ( game_start      ),
        .dip_test       ( dip_test        ),
        .dip_pause      ( dip_pause       ),
        .dip_flip       ( dip_flip        ),
        .enable_fm      ( enable_fm       ),
        .enable_psg     ( enable_psg      ),
        .led            ( led             ),
        .dip_fxlevel    ( dip_fxlevel     ),
        .rotate         ( rotate          )
    );

    always #(PERIOD / 2) clk_sys = ~clk_sys;

    // Low bits with up/down and left/right exchanged on flip and polarity applied
    function automatic logic [JOY_W-1:0] expected_joystick(
        input logic [BOARD_JOY_W-1:0] joy,
        input logic                   flip
    );
        logic [JOY_W-1:0] low;
        low = joy[JOY_W-1:0];
        if (flip) begin
            low[3:0] = {joy[2], joy[3], joy[0], joy[1]};
        end
        return low ^ {JOY_W{IDLE}};
    endfunction

    task automatic report_mismatch(input string what);
        $display("** Error at %0t ns: %s differs from the expected value", $time, what);
        $display("Result: FAILED");
        $fatal(1, "Mismatch on %s", what);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    task automatic wait_game_running(input int max_cycles);
        int waited;
        waited = 0;
        while (game_rst !== 1'b0 && waited < max_cycles) begin
            step(1);
            waited++;
        end
        if (game_rst !== 1'b0) abort_run("game_rst was not released in time");
    endtask

    // Reset sequence counted in edges since reset or rst_req was last seen
    always @(posedge clk_sys) begin
        if (reset || rst_req) begin
            edge_n    <= 0;
            game_left <= GAME_LEN;
            waiting   <= 1'b0;
            rst_m     <= 1'b1;
            init_m    <= 1'b1;
            game_m    <= 1'b1;
        end else begin
            if (edge_n < 1000) edge_n <= edge_n + 1;
            rst_m  <= edge_n + 1 < HOLD_LEN;
            init_m <= edge_n + 1 < HOLD_LEN + INIT_LEN;
            if (edge_n + 1 < HOLD_LEN + INIT_LEN) begin
                game_m <= 1'b1;
            end else if (edge_n + 1 == HOLD_LEN + INIT_LEN) begin
                game_left <= GAME_LEN;
                waiting   <= downloading;
                game_m    <= 1'b1;
            end else if (downloading || waiting) begin
                // Count restarts at the first edge with downloading low
                game_left <= GAME_LEN;
                waiting   <= downloading;
                game_m    <= 1'b1;
            end else if (!game_m && soft_m) begin
                game_left <= GAME_LEN;
                game_m    <= 1'b1;
            end else if (game_left > 0) begin
                game_left <= game_left - 1;
                game_m    <= game_left > 1;
            end
        end
    end

    // Inputs and DIP settings
    always @(posedge clk_sys) begin
        if (rst_m) begin
            joy1_m     <= {JOY_W{IDLE}};
            joy2_m     <= {JOY_W{IDLE}};
            coin_m     <= {PLAYERS{IDLE}};
            start_m    <= {PLAYERS{IDLE}};
            pause_m    <= 1'b0;
            pause_prev <= 1'b0;
            combo_prev <= 1'b0;
            soft_m     <= 1'b0;
            {test_m, dpause_m, flip_m, fm_m, psg_m, fx_m, rot_m} <= '0;
        end else begin
            joy1_m     <= expected_joystick(board_joystick1, flip_m);
            joy2_m     <= expected_joystick(board_joystick2, flip_m);
            coin_m     <= board_coin ^ {PLAYERS{IDLE}};
            start_m    <= board_start ^ {PLAYERS{IDLE}};
            pause_prev <= board_joystick1[JOY_PAUSE];
            if (board_joystick1[JOY_PAUSE] && !pause_prev) pause_m <= !pause_m;
            combo_prev <= board_start[0] && board_coin[0];
            soft_m     <= board_start[0] && board_coin[0] && !combo_prev;
            test_m     <= status[ST_TEST];
            flip_m     <= status[ST_FLIP];
            fx_m       <= status[ST_FX_LO +: 2];
            rot_m      <= status[ST_ROT_LO +: 2];
            dpause_m   <= status[ST_PAUSE] || pause_m;
            fm_m       <= !status[ST_NO_FM];
            psg_m      <= !status[ST_NO_PSG];
        end
    end

    // LED with frame counted blink
    always @(posedge clk_sys) begin
        if (rst_m) begin
            lvbl_prev <= 1'b0;
            dl_prev   <= 1'b0;
            led_m     <= 1'b0;
            blink_m    = 1'b1;
            frames     = 0;
        end else begin
            if (downloading && !dl_prev) begin
                blink_m = 1'b1;
                frames  = 0;
            end else if (downloading && lvbl_prev && !LVBL) begin
                frames = frames + 1;
                if (frames == BLINK_FRAMES) begin
                    frames  = 0;
                    blink_m = !blink_m;
                end
            end
            lvbl_prev <= LVBL;
            dl_prev   <= downloading;
            if (downloading) led_m <= blink_m;
            else if (osd_shown) led_m <= 1'b1;
            else led_m <= game_led;
        end
    end

    assert property (@(posedge clk_sys) disable iff (!checking) rst == rst_m)
        else report_mismatch("rst");
    assert property (@(posedge clk_sys) disable iff (!checking) sdram_init == init_m)
        else report_mismatch("sdram_init");
    assert property (@(posedge clk_sys) disable iff (!checking) game_rst == game_m)
        else report_mismatch("game_rst");
    assert property (@(posedge clk_sys) disable iff (!checking) game_joystick1 == joy1_m)
        else report_mismatch("game_joystick1");
    assert property (@(posedge clk_sys) disable iff (!checking) game_joystick2 == joy2_m)
        else report_mismatch("game_joystick2");
    assert property (@(posedge clk_sys) disable iff (!checking) game_coin == coin_m)
        else report_mismatch("game_coin");
    assert property (@(posedge clk_sys) disable iff (!checking) game_start == start_m)
        else report_mismatch("game_start");
    assert property (@(posedge clk_sys) disable iff (!checking) dip_test == test_m)
        else report_mismatch("dip_test");
    assert property (@(posedge clk_sys) disable iff (!checking) dip_pause == dpause_m)
        else report_mismatch("dip_pause");
    assert property (@(posedge clk_sys) disable iff (!checking) dip_flip == flip_m)
        else report_mismatch("dip_flip");
    assert property (@(posedge clk_sys) disable iff (!checking) dip_fxlevel == fx_m)
        else report_mismatch("dip_fxlevel");
    assert property (@(posedge clk_sys) disable iff (!checking) rotate == rot_m)
        else report_mismatch("rotate");
    assert property (@(posedge clk_sys) disable iff (!checking) enable_fm == fm_m)
        else report_mismatch("enable_fm");
    assert property (@(posedge clk_sys) disable iff (!checking) enable_psg == psg_m)
        else report_mismatch("enable_psg");
    assert property (@(posedge clk_sys) disable iff (!checking) led == led_m)
        else report_mismatch("led");

    initial begin
        #(TEST_CYCLES * PERIOD + MARGIN_CYCLES * PERIOD);
        abort_run("Watchdog timeout: the tests did not finish in time");
    end

    initial begin
        seed            = 32'h4ef6;
        checking        = 1'b0;
        reset           = 1'b1;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_coin      = '0;
        board_start     = '0;
        status          = '0;
        LVBL            = 1'b0;
        osd_shown       = 1'b0;
        game_led        = 1'b0;
        step(2);
        checking = 1'b1;
        step(2);
        reset = 1'b0;
        wait_game_running(HOLD_LEN + INIT_LEN + GAME_LEN + 8);

        // Random joysticks, coins, starts and status words
        for (int i = 0; i < 48; i++) begin
            board_joystick1 = 16'($random(seed));
            board_joystick2 = 16'($random(seed));
            board_coin      = 2'($random(seed));
            board_start     = 2'($random(seed));
            status          = $random(seed);
            status[ST_FLIP] = i[3];
            step(1);
        end
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_coin      = '0;
        board_start     = '0;
        status          = '0;
        wait_game_running(GAME_LEN + 8);

        // Pause presses
        for (int i = 0; i < 3; i++) begin
            board_joystick1[JOY_PAUSE] = 1'b1;
            step(2);
            board_joystick1[JOY_PAUSE] = 1'b0;
            step(3);
        end

        // Start 1 with coin 1 in run
        board_start[0] = 1'b1;
        board_coin[0]  = 1'b1;
        step(3);
        board_start[0] = 1'b0;
        board_coin[0]  = 1'b0;
        step(1);
        wait_game_running(GAME_LEN + 4);

        // Download with LVBL frames
        downloading = 1'b1;
        for (int i = 0; i < 32; i++) begin
            LVBL      = (i % 4) < 2;
            osd_shown = 1'($random(seed));
            game_led  = 1'($random(seed));
            step(1);
        end
        downloading = 1'b0;
        step(1);
        wait_game_running(GAME_LEN + 4);

        // LED outside a download
        for (int i = 0; i < 20; i++) begin
            LVBL      = 1'($random(seed));
            osd_shown = 1'($random(seed));
            game_led  = 1'($random(seed));
            step(1);
        end

        // Reset request in run and another with a download across the SDRAM init end
        rst_req = 1'b1;
        step(1);
        rst_req = 1'b0;
        wait_game_running(HOLD_LEN + INIT_LEN + GAME_LEN + 8);
        rst_req = 1'b1;
        step(1);
        rst_req = 1'b0;
        step(HOLD_LEN + INIT_LEN - 4);
        downloading = 1'b1;
        step(8);
        downloading = 1'b0;
        wait_game_running(GAME_LEN + 8);
        step(4);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== rtl/board_top.sv ====
// ################################################
// Board support top level
// Reset sequencing, input mapping, DIP decode and LED
// ################################################
`timescale 1ns/1ps

module board_top #(
    parameter int HOLD_LEN     = 64,
    parameter int INIT_LEN     = 256,
    parameter int GAME_LEN     = 64,
    parameter int COUNT_W      = 10,
    parameter int BLINK_FRAMES = 16,
    parameter int ACTIVE_LOW   = 1
) (
    input  logic                               clk_sys,
    input  logic                               reset,
    input  logic                               rst_req,
    input  logic                               downloading,

    input  logic [board_pkg::BOARD_JOY_W-1:0]  board_joystick1,
    input  logic [board_pkg::BOARD_JOY_W-1:0]  board_joystick2,
    input  logic [board_pkg::PLAYERS-1:0]      board_coin,
    input  logic [board_pkg::PLAYERS-1:0]      board_start,

    input  logic [board_pkg::STATUS_W-1:0]     status,

    input  logic                               LVBL,
    input  logic                               osd_shown,
    input  logic                               game_led,

    output logic                               rst,
    output logic                               sdram_init,
    output logic                               game_rst,

    output logic [board_pkg::JOY_W-1:0]        game_joystick1,
    output logic [board_pkg::JOY_W-1:0]        game_joystick2,
    output logic [board_pkg::PLAYERS-1:0]      game_coin,
    output logic [board_pkg::PLAYERS-1:0]      game_start,

    output logic                               dip_test,
    output logic                               dip_pause,
    output logic                               dip_flip,
    output logic                               enable_fm,
    output logic                               enable_psg,
    output logic                               led,
    output logic [1:0]                         dip_fxlevel,
    output logic [1:0]                         rotate
);

    logic               timer_start;
    logic               timer_done;
    logic [COUNT_W-1:0] timer_len;
    logic               soft_rst;
    logic               game_pause;

    board_reset_seq #(
        .HOLD_LEN   ( HOLD_LEN      ),
        .INIT_LEN   ( INIT_LEN      ),
        .GAME_LEN   ( GAME_LEN      ),
        .COUNT_W    ( COUNT_W       )
    ) u_reset_seq (
        .clk_sys    ( clk_sys       ),
        .reset      ( reset         ),
        .rst_req    ( rst_req       ),
        .downloading( downloading   ),
        .soft_rst   ( soft_rst      ),
        .timer_done ( timer_done    ),
        .timer_start( timer_start   ),
        .timer_len  ( timer_len     ),
        .rst        ( rst           ),
        .sdram_init ( sdram_init    ),
        .game_rst   ( game_rst      )
    );

    board_timer #(
        .COUNT_W    ( COUNT_W       )
    ) u_timer (
        .clk_sys    ( clk_sys       ),
        .reset      ( reset         ),
        .start      ( timer_start   ),
        .len        ( timer_len     ),
        .done       ( timer_done    )
    );

    board_inputs #(
        .ACTIVE_LOW ( ACTIVE_LOW    )
    ) u_inputs (
        .clk_sys        ( clk_sys           ),
        .rst            ( rst               ),
        .dip_flip       ( dip_flip          ),
        .board_joystick1( board_joystick1   ),
        .board_joystick2( board_joystick2   ),
        .board_coin     ( board_coin        ),
        .board_start    ( board_start       ),
        .game_joystick1 ( game_joystick1    ),
        .game_joystick2 ( game_joystick2    ),
        .game_coin      ( game_coin         ),
        .game_start     ( game_start        ),
        .game_pause     ( game_pause        ),
        .soft_rst       ( soft_rst          )
    );

    board_dip u_dip (
        .clk_sys    ( clk_sys       ),
        .rst        ( rst           ),
        .status     ( status        ),
        .game_pause ( game_pause    ),
        .dip_test   ( dip_test      ),
        .dip_pause  ( dip_pause     ),
        .dip_flip   ( dip_flip      ),
        .dip_fxlevel( dip_fxlevel   ),
        .enable_fm  ( enable_fm     ),
        .enable_psg ( enable_psg    ),
        .rotate     ( rotate        )
    );

    board_led #(
        .BLINK_FRAMES( BLINK_FRAMES )
    ) u_led (
        .clk_sys    ( clk_sys       ),
        .rst        ( rst           ),
        .downloading( downloading   ),
        .osd_shown  ( osd_shown     ),
        .game_led   ( game_led      ),
        .LVBL       ( LVBL          ),
        .led        ( led           )
    );

endmodule

// ==== rtl/board_led.sv ====
// ################################################
// Status LED
// Blinks during download, else OSD or game LED
// ################################################
`timescale 1ns/1ps

module board_led #(
    parameter int BLINK_FRAMES = 16
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic osd_shown,
    input  logic game_led,
    input  logic LVBL,
    output logic led
);

    localparam int CNT_W = BLINK_FRAMES > 1 ? $clog2(BLINK_FRAMES) : 1;

    logic             lvbl_q;
    logic             dl_q;
    logic             frame_end;
    logic             dl_start;
    logic             blink;
    logic             blink_nx;
    logic [CNT_W-1:0] frame_cnt;
    logic [CNT_W-1:0] frame_cnt_nx;

    // Falling edge of LVBL marks a new frame
    assign frame_end = lvbl_q & ~LVBL;
    assign dl_start  = downloading & ~dl_q;

    always_comb begin
        blink_nx     = blink;
        frame_cnt_nx = frame_cnt;
        if (dl_start) begin
            blink_nx     = 1'b1;
            frame_cnt_nx = '0;
        end else if (downloading && frame_end) begin
            if (frame_cnt == CNT_W'(BLINK_FRAMES - 1)) begin
                frame_cnt_nx = '0;
                blink_nx     = ~blink;
            end else begin
                frame_cnt_nx = frame_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            lvbl_q    <= 1'b0;
            dl_q      <= 1'b0;
            blink     <= 1'b1;
            frame_cnt <= '0;
            led       <= 1'b0;
        end else begin
            lvbl_q    <= LVBL;
            dl_q      <= downloading;
            blink     <= blink_nx;
            frame_cnt <= frame_cnt_nx;
            // Download first, then OSD, then the game
            led       <= downloading ? blink_nx : (osd_shown | game_led);
        end
    end

endmodule

// ==== rtl/board_dip.sv ====
// ################################################
// DIP decoder
// OSD status word to registered DIP settings
// ################################################
`timescale 1ns/1ps

module board_dip (
    input  logic                            clk_sys,
    input  logic                            rst,
    input  logic [board_pkg::STATUS_W-1:0]  status,
    input  logic                            game_pause,
    output logic                            dip_test,
    output logic                            dip_pause,
    output logic                            dip_flip,
    output logic [1:0]                      dip_fxlevel,
    output logic                            enable_fm,
    output logic                            enable_psg,
    output logic [1:0]                      rotate
);
    import board_pkg::*;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dip_test    <= 1'b0;
            dip_pause   <= 1'b0;
            dip_flip    <= 1'b0;
            dip_fxlevel <= 2'd0;
            enable_fm   <= 1'b0;
            enable_psg  <= 1'b0;
            rotate      <= 2'd0;
        end else begin
            dip_test    <= status[ST_TEST];
            dip_flip    <= status[ST_FLIP];
            dip_fxlevel <= status[ST_FX_LO +: 2];
            rotate      <= status[ST_ROT_LO +: 2];
            // Pause from the OSD or from the player's button
            dip_pause   <= status[ST_PAUSE] | game_pause;
            // Status bits disable the sound chips
            enable_fm   <= ~status[ST_NO_FM];
            enable_psg  <= ~status[ST_NO_PSG];
        end
    end

endmodule

// ==== rtl/board_inputs.sv ====
// ################################################
// Input mapper
// Joysticks, coins and starts to game inputs, plus pause
// ################################################
`timescale 1ns/1ps

module board_inputs #(
    parameter int ACTIVE_LOW = 1
) (
    input  logic                               clk_sys,
    input  logic                               rst,
    input  logic                               dip_flip,
    input  logic [board_pkg::BOARD_JOY_W-1:0]  board_joystick1,
    input  logic [board_pkg::BOARD_JOY_W-1:0]  board_joystick2,
    input  logic [board_pkg::PLAYERS-1:0]      board_coin,
    input  logic [board_pkg::PLAYERS-1:0]      board_start,
    output logic [board_pkg::JOY_W-1:0]        game_joystick1,
    output logic [board_pkg::JOY_W-1:0]        game_joystick2,
    output logic [board_pkg::PLAYERS-1:0]      game_coin,
    output logic [board_pkg::PLAYERS-1:0]      game_start,
    output logic                               game_pause,
    output logic                               soft_rst
);
    import board_pkg::*;

    // Output level of a button that is not pressed
    localparam logic POL = ACTIVE_LOW != 0;

    logic pause_q;
    logic combo;
    logic combo_q;

    // Keep the low bits and swap directions on a flipped screen
    function automatic logic [JOY_W-1:0] map_joy(
        input logic [BOARD_JOY_W-1:0] joy,
        input logic                   flip
    );
        logic [JOY_W-1:0] m;
        m = joy[JOY_W-1:0];
        if (flip) begin
            m[JOY_UP]    = joy[JOY_DOWN];
            m[JOY_DOWN]  = joy[JOY_UP];
            m[JOY_LEFT]  = joy[JOY_RIGHT];
            m[JOY_RIGHT] = joy[JOY_LEFT];
        end
        return m;
    endfunction

    // Player 1 start and coin together
    assign combo = board_start[0] & board_coin[0];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= {JOY_W{POL}};
            game_joystick2 <= {JOY_W{POL}};
            game_coin      <= {PLAYERS{POL}};
            game_start     <= {PLAYERS{POL}};
            game_pause     <= 1'b0;
            pause_q        <= 1'b0;
            combo_q        <= 1'b0;
            soft_rst       <= 1'b0;
        end else begin
            game_joystick1 <= map_joy(board_joystick1, dip_flip) ^ {JOY_W{POL}};
            game_joystick2 <= map_joy(board_joystick2, dip_flip) ^ {JOY_W{POL}};
            game_coin      <= board_coin ^ {PLAYERS{POL}};
            game_start     <= board_start ^ {PLAYERS{POL}};

            // Pause toggles on each press
            pause_q <= board_joystick1[JOY_PAUSE];
            if (board_joystick1[JOY_PAUSE] && !pause_q) begin
                game_pause <= ~game_pause;
            end

            combo_q  <= combo;
            soft_rst <= combo & ~combo_q;
        end
    end

endmodule

// ==== rtl/board_reset_seq.sv ====
// ################################################
// Reset sequencer
// Orders board, SDRAM init and game resets
// ################################################
`timescale 1ns/1ps

module board_reset_seq #(
    parameter int HOLD_LEN = 64,
    parameter int INIT_LEN = 256,
    parameter int GAME_LEN = 64,
    parameter int COUNT_W  = 10
) (
    input  logic               clk_sys,
    input  logic               reset,
    input  logic               rst_req,
    input  logic               downloading,
    input  logic               soft_rst,
    input  logic               timer_done,
    output logic               timer_start,
    output logic [COUNT_W-1:0] timer_len,
    output logic               rst,
    output logic               sdram_init,
    output logic               game_rst
);
    import board_pkg::*;

    // Start reaches the timer one edge after the state change
    localparam logic [COUNT_W-1:0] HOLD_CNT = COUNT_W'(HOLD_LEN - 1);
    localparam logic [COUNT_W-1:0] INIT_CNT = COUNT_W'(INIT_LEN - 1);
    localparam logic [COUNT_W-1:0] GAME_CNT = COUNT_W'(GAME_LEN - 1);

    reset_state_t state;
    reset_state_t state_nx;
    logic         start_nx;
    logic         wait_dl;
    logic         wait_dl_nx;
    logic         phase_end;

    // A done seen while the timer reloads belongs to an older count
    assign phase_end = timer_done & ~timer_start;

    always_comb begin
        case (state)
            st_hold: timer_len = HOLD_CNT;
            st_init: timer_len = INIT_CNT;
            default: timer_len = GAME_CNT;
        endcase
    end

    always_comb begin
        state_nx   = state;
        start_nx   = 1'b0;
        wait_dl_nx = wait_dl;
        case (state)
            st_hold: begin
                if (phase_end) begin
                    state_nx = st_init;
                    start_nx = 1'b1;
                end
            end
            st_init: begin
                if (phase_end) begin
                    state_nx   = st_game_hold;
                    start_nx   = 1'b1;
                    wait_dl_nx = downloading;
                end
            end
            st_game_hold: begin
                // Count again from the first edge with downloading low
                if (downloading) begin
                    wait_dl_nx = 1'b1;
                end else if (wait_dl) begin
                    start_nx   = 1'b1;
                    wait_dl_nx = 1'b0;
                end else if (phase_end) begin
                    state_nx = st_run;
                end
            end
            st_run: begin
                if (downloading) begin
                    state_nx   = st_game_hold;
                    wait_dl_nx = 1'b1;
                end else if (soft_rst) begin
                    state_nx = st_game_hold;
                    start_nx = 1'b1;
                end
            end
            default: state_nx = st_hold;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset || rst_req) begin
            state       <= st_hold;
            timer_start <= 1'b1;
            wait_dl     <= 1'b0;
            rst         <= 1'b1;
            sdram_init  <= 1'b1;
            game_rst    <= 1'b1;
        end else begin
            state       <= state_nx;
            timer_start <= start_nx;
            wait_dl     <= wait_dl_nx;
            rst         <= state_nx == st_hold;
            sdram_init  <= state_nx == st_hold || state_nx == st_init;
            game_rst    <= state_nx != st_run;
        end
    end

endmodule

// ==== rtl/board_timer.sv ====
// ################################################
// Phase timer
// Loadable down counter with a single done pulse
// ################################################
`timescale 1ns/1ps

module board_timer #(
    parameter int COUNT_W = 10
) (
    input  logic               clk_sys,
    input  logic               reset,
    input  logic               start,
    input  logic [COUNT_W-1:0] len,
    output logic               done
);

    logic [COUNT_W-1:0] cnt;

    // Zero means idle
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= len;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Pulses on the last count, which ends len cycles after start
    assign done = cnt == COUNT_W'(1);

endmodule

// ==== rtl/board_pkg.sv ====
// ################################################
// Board support package
// Sequencer state, input widths and OSD status fields
// ################################################
package board_pkg;

    // Reset sequencer phases
    typedef enum logic [1:0] {
        st_hold,
        st_init,
        st_game_hold,
        st_run
    } reset_state_t;

    // Joystick and player widths
    localparam int JOY_W       = 10;
    localparam int BOARD_JOY_W = 16;
    localparam int PLAYERS     = 2;

    localparam int STATUS_W    = 32;

    // Direction bits of a joystick
    // Button 1 sits at bit 4
    localparam int JOY_RIGHT   = 0;
    localparam int JOY_LEFT    = 1;
    localparam int JOY_DOWN    = 2;
    localparam int JOY_UP      = 3;

    // Pause button on board joystick 1
    localparam int JOY_PAUSE   = 9;

    // OSD status word fields
    localparam int ST_FLIP     = 1;
    localparam int ST_PAUSE    = 2;
    localparam int ST_FX_LO    = 3;   // two bits
    localparam int ST_TEST     = 5;
    localparam int ST_NO_FM    = 6;
    localparam int ST_NO_PSG   = 7;
    localparam int ST_ROT_LO   = 8;   // two bits

endpackage
